/* sim/fp_result_monitor_properties.sv */
`timescale 1ns/1ps

module fp_result_monitor_properties
    import fp_check_pkg::*;
(
    input logic      clk,
    input logic      i_rst,
    input logic      i_valid,
    input logic      o_valid,
    input rule_vec_t o_rule_viol,
    input vcount_t   o_viol_count
);

    // two register stages between the input strobe and the output strobe
    property p_valid_latency;
        @(posedge clk) disable iff (i_rst)
            (!$past(i_rst, 1) && !$past(i_rst, 2)) |-> (o_valid == $past(i_valid, 2));
    endproperty

    // saturating counter only moves up
    property p_count_monotonic;
        @(posedge clk) disable iff (i_rst)
            !$past(i_rst) |-> (o_viol_count >= $past(o_viol_count));
    endproperty

    // a new count shows up only together with a failing output
    property p_count_on_viol;
        @(posedge clk) disable iff (i_rst)
            (!$past(i_rst) && $changed(o_viol_count)) |-> (o_valid && (o_rule_viol != '0));
    endproperty

    a_valid_latency: assert property (p_valid_latency)
        else $error("o_valid does not follow i_valid by two cycles");

    a_count_monotonic: assert property (p_count_monotonic)
        else $error("violation count decreased");

    a_count_on_viol: assert property (p_count_on_viol)
        else $error("violation count changed without a failing output");

endmodule

bind fp_result_monitor fp_result_monitor_properties u_props (
    .clk          (clk),
    .i_rst        (i_rst),
    .i_valid      (i_valid),
    .o_valid      (o_valid),
    .o_rule_viol  (o_rule_viol),
    .o_viol_count (o_viol_count)
);

/* sim/tb_fp_result_monitor.sv */
`timescale 1ns/1ps
`include "fp_check_macros.svh"

module tb_fp_result_monitor
    import fp_check_pkg::*;
();

    localparam int NUM_TXN        = 2000;
    // about 1.43 cycles per transaction at 70% valid, plus drain margin
    localparam int TIMEOUT_CYCLES = NUM_TXN * 3;

    logic      clk = 1'b0;
    logic      i_rst;
    logic      i_valid;
    fp32_t     i_a;
    fp32_t     i_b;
    fp32_t     i_c;
    rm_t       i_rm;
    fp32_t     i_result;
    fp_flags_t i_flags;
    logic      o_valid;
    rule_vec_t o_rule_viol;
    vcount_t   o_viol_count;

    rule_vec_t exp_q[$];
    rule_vec_t exp_vec;
    rule_vec_t last_viol = '0;
    vcount_t   model_count = '0;
    logic [1:0] valid_hist = '0;
    int        cycle_count = 0;

    fp_result_monitor uut (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_valid      (i_valid),
        .i_a          (i_a),
        .i_b          (i_b),
        .i_c          (i_c),
        .i_rm         (i_rm),
        .i_result     (i_result),
        .i_flags      (i_flags),
        .o_valid      (o_valid),
        .o_rule_viol  (o_rule_viol),
        .o_viol_count (o_viol_count)
    );

    always #20 clk = ~clk;

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("ERROR [%0t] %s: got %h, expected %h", $time, what, actual, expected);
            $display("TESTBENCH FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    function automatic fp_class_t classify_ref(fp32_t v);
        fp_class_t  c;
        logic [7:0] e;
        logic [22:0] f;
        e = v[30:23];
        f = v[22:0];
        c = '0;
        c[CLS_SIGN] = v[31];
        c[CLS_ZERO] = (v[30:0] == 31'd0);
        if (e == 8'hff) begin
            if (f == 23'd0)
                c[CLS_INF] = 1'b1;
            else if (f[22])
                c[CLS_QNAN] = 1'b1;
            else
                c[CLS_SNAN] = 1'b1;
        end else if (e != 8'd0) begin
            c[CLS_NORMAL] = 1'b1;
        end else if (f != 23'd0) begin
            c[CLS_SUBNORM] = 1'b1;
        end
        c[CLS_FINITE]  = c[CLS_NORMAL] | c[CLS_SUBNORM];
        c[CLS_CLAMPED] = (v[30:0] == `FP_MAG_MAX);
        c[CLS_EBMIN]   = (e == 8'd1) && (f == 23'd0);
        return c;
    endfunction

    function automatic rule_vec_t expected_rules(fp32_t a, fp32_t b, fp32_t c, rm_t rm,
                                                 fp32_t res, fp_flags_t fl);
        fp_class_t ca;
        fp_class_t cb;
        fp_class_t cc;
        fp_class_t cr;
        logic      nan_in;
        logic      snan_in;
        logic      allowed;
        logic      toward;
        int        mode;
        rule_vec_t r;
        ca = classify_ref(a);
        cb = classify_ref(b);
        cc = classify_ref(c);
        cr = classify_ref(res);
        r  = '0;
        snan_in = ca[CLS_SNAN] | cb[CLS_SNAN] | cc[CLS_SNAN];
        nan_in  = snan_in | ca[CLS_QNAN] | cb[CLS_QNAN] | cc[CLS_QNAN];
        r[R_NAN_PROP]  = nan_in && !(cr[CLS_QNAN] || cr[CLS_SNAN]);
        r[R_NAN_QUIET] = nan_in && (fl[FLG_DZ] || fl[FLG_OF] || fl[FLG_UF] || fl[FLG_NX]);
        r[R_SNAN_NV]   = snan_in && !fl[FLG_NV];
        r[R_DZ_INF]    = fl[FLG_DZ] && !cr[CLS_INF];
        r[R_NV_QNAN]   = fl[FLG_NV] && !cr[CLS_QNAN];
        r[R_OF_NX]     = fl[FLG_OF] && !fl[FLG_NX];
        r[R_UF_NX]     = fl[FLG_UF] && !fl[FLG_NX];
        r[R_UF_CLASS]  = fl[FLG_UF] && !(cr[CLS_SUBNORM] || cr[CLS_ZERO] || cr[CLS_EBMIN]);
        r[R_EXACT_INF] = cr[CLS_INF] && !fl[FLG_OF] && fl[FLG_NX];
        r[R_EXACT_SUB] = cr[CLS_SUBNORM] && !fl[FLG_UF] && fl[FLG_NX];
        // lowest set bit wins, empty mode means RTZ
        mode = RM_RTZ;
        for (int i = RM_RTN; i >= RM_RNE; i--) begin
            if (rm[i])
                mode = i;
        end
        case (mode)
            RM_RNE, RM_RNA: allowed = (res == `FP_POS_INF) || (res == `FP_NEG_INF);
            RM_RTP:         allowed = (res == `FP_POS_INF) || (res == `FP_NEG_MAX);
            RM_RTN:         allowed = (res == `FP_POS_MAX) || (res == `FP_NEG_INF);
            default:        allowed = (res == `FP_POS_MAX) || (res == `FP_NEG_MAX);
        endcase
        toward = res[31] ? (mode == RM_RTN) : (mode == RM_RTP);
        r[R_OF_VALUE]  = fl[FLG_OF] && !allowed;
        r[R_DIRECTION] = ((fl[FLG_UF] && cr[CLS_EBMIN]) || (fl[FLG_OF] && cr[CLS_INF])) &&
                         !(mode == RM_RNE || mode == RM_RNA || toward);
        r[R_RM_ONEHOT] = ($countones(rm) != 1);
        return r;
    endfunction

    // half special encodings, half raw random words
    function automatic fp32_t pick_value();
        fp32_t v;
        if ($urandom_range(1, 0) == 0) begin
            case ($urandom_range(13, 0))
                0:       v = 32'h0000_0000;
                1:       v = 32'h8000_0000;
                2:       v = `FP_POS_MAX;
                3:       v = `FP_NEG_MAX;
                4:       v = `FP_POS_INF;
                5:       v = `FP_NEG_INF;
                6:       v = 32'h7fc0_0000;
                7:       v = 32'hffc0_0001;
                8:       v = 32'h7f80_0001;
                9:       v = 32'hff81_2345;
                10:      v = 32'h0080_0000;
                11:      v = 32'h8080_0000;
                12:      v = 32'h0000_0001;
                default: v = 32'h8000_0003;
            endcase
        end else begin
            v = $urandom();
        end
        return v;
    endfunction

    initial begin
        fp32_t     a;
        fp32_t     b;
        fp32_t     c;
        fp32_t     res;
        rm_t       rm;
        fp_flags_t fl;
        int        sent;
        void'($urandom(32'h2e4a_9da4));
        i_rst    = 1'b1;
        i_valid  = 1'b0;
        i_a      = '0;
        i_b      = '0;
        i_c      = '0;
        i_rm     = rm_t'(1);
        i_result = '0;
        i_flags  = '0;
        sent     = 0;
        repeat (8) @(posedge clk);
        i_rst <= 1'b0;
        while (sent < NUM_TXN) begin
            @(posedge clk);
            if ($urandom_range(99, 0) < 70) begin
                a   = pick_value();
                b   = pick_value();
                c   = pick_value();
                res = pick_value();
                fl  = fp_flags_t'($urandom());
                if ($urandom_range(9, 0) != 0)
                    rm = rm_t'(1) << $urandom_range(4, 0);
                else
                    rm = rm_t'($urandom());
                exp_q.push_back(expected_rules(a, b, c, rm, res, fl));
                i_valid  <= 1'b1;
                i_a      <= a;
                i_b      <= b;
                i_c      <= c;
                i_rm     <= rm;
                i_result <= res;
                i_flags  <= fl;
                sent++;
            end else begin
                i_valid <= 1'b0;
            end
        end
        @(posedge clk);
        i_valid <= 1'b0;
        while (exp_q.size() != 0)
            @(posedge clk);
        repeat (3) @(posedge clk);
        $display("TESTBENCH PASSED");
        $finish;
    end

    // outputs are sampled mid-cycle, away from the driving edge
    always @(negedge clk) begin
        check_value(o_valid, valid_hist[1], "o_valid latency");
        if (o_valid) begin
            exp_vec = exp_q.pop_front();
            if (exp_vec != '0 && model_count != '1)
                model_count = model_count + 1'b1;
            check_value(o_rule_viol, exp_vec, "o_rule_viol");
            last_viol = exp_vec;
        end else begin
            check_value(o_rule_viol, last_viol, "o_rule_viol held");
        end
        check_value(o_viol_count, model_count, "o_viol_count");
        valid_hist = {valid_hist[0], i_valid & !i_rst};
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TESTBENCH FAILED");
            $fatal(1, "timeout");
        end
    end

endmodule

/* src.f */
+incdir+verilog
verilog/fp_check_pkg.sv
verilog/fp_classify.sv
verilog/fp_exception_rules.sv
verilog/fp_rounding_rules.sv
verilog/fp_result_monitor.sv
sim/fp_result_monitor_properties.sv
sim/tb_fp_result_monitor.sv

/* verilog/fp_check_macros.svh */
`ifndef FP_CHECK_MACROS_SVH
`define FP_CHECK_MACROS_SVH

// single-precision word layout
`define FP_WIDTH        32
`define FP_EXP_WIDTH    8
`define FP_FRAC_WIDTH   23

// sign sits on the top bit, exponent directly below it
`define FP_SIGN_POS     31

// all-ones exponent marks inf and NaN
`define FP_EXP_MAX      8'hff

// largest finite magnitude, sign bit excluded
`define FP_MAG_MAX      31'h7f7fffff

// overflow encodings allowed by the rounding modes
`define FP_POS_MAX      32'h7f7fffff
`define FP_NEG_MAX      32'hff7fffff
`define FP_POS_INF      32'h7f800000
`define FP_NEG_INF      32'hff800000

// rule vector and violation counter sizes
`define RULE_COUNT      13
`define VCOUNT_WIDTH    16

`endif

/* verilog/fp_check_pkg.sv */
`include "fp_check_macros.svh"

package fp_check_pkg;

    // raw fields of a single-precision value
    typedef logic [`FP_WIDTH-1:0]      fp32_t;
    typedef logic [`FP_EXP_WIDTH-1:0]  fp_exp_t;
    typedef logic [`FP_FRAC_WIDTH-1:0] fp_frac_t;

    // class vector, one bit per property of a value
    localparam int CLS_SIGN    = 0;
    localparam int CLS_ZERO    = 1;
    localparam int CLS_NORMAL  = 2;
    localparam int CLS_SUBNORM = 3;
    localparam int CLS_INF     = 4;
    localparam int CLS_QNAN    = 5;
    localparam int CLS_SNAN    = 6;
    localparam int CLS_FINITE  = 7;
    localparam int CLS_CLAMPED = 8;
    localparam int CLS_EBMIN   = 9;
    typedef logic [CLS_EBMIN:0] fp_class_t;

    // exception flags, same order as the RISC-V fflags field
    localparam int FLG_NX = 0;
    localparam int FLG_UF = 1;
    localparam int FLG_OF = 2;
    localparam int FLG_DZ = 3;
    localparam int FLG_NV = 4;
    typedef logic [FLG_NV:0] fp_flags_t;

    // one-hot rounding mode
    localparam int RM_RNE = 0;
    localparam int RM_RNA = 1;
    localparam int RM_RTP = 2;
    localparam int RM_RTN = 3;
    localparam int RM_RTZ = 4;
    typedef logic [RM_RTZ:0] rm_t;

    // violation vector, a set bit means the rule is broken
    localparam int R_NAN_PROP  = 0;
    localparam int R_NAN_QUIET = 1;
    localparam int R_SNAN_NV   = 2;
    localparam int R_DZ_INF    = 3;
    localparam int R_NV_QNAN   = 4;
    localparam int R_OF_NX     = 5;
    localparam int R_UF_NX     = 6;
    localparam int R_UF_CLASS  = 7;
    localparam int R_EXACT_INF = 8;
    localparam int R_EXACT_SUB = 9;
    localparam int R_OF_VALUE  = 10;
    localparam int R_DIRECTION = 11;
    localparam int R_RM_ONEHOT = 12;
    typedef logic [`RULE_COUNT-1:0] rule_vec_t;

    typedef logic [`VCOUNT_WIDTH-1:0] vcount_t;

endpackage

/* verilog/fp_classify.sv */
`timescale 1ns/1ps
`include "fp_check_macros.svh"

module fp_classify
    import fp_check_pkg::*;
(
    input  fp32_t     i_value,
    output fp_class_t o_class
);

    logic     sign;
    fp_exp_t  exp_field;
    fp_frac_t frac;
    logic     exp_zero;
    logic     frac_zero;
    logic     special;
    logic     is_nan;

    // field split
    assign sign      = i_value[`FP_SIGN_POS];
    assign exp_field = i_value[`FP_SIGN_POS-1 -: `FP_EXP_WIDTH];
    assign frac      = i_value[`FP_FRAC_WIDTH-1:0];

    assign exp_zero  = (exp_field == '0);
    assign frac_zero = (frac == '0);

    // all-ones exponent covers both inf and NaN
    assign special = (exp_field == `FP_EXP_MAX);
    assign is_nan  = special && !frac_zero;

    assign o_class[CLS_SIGN] = sign;
    assign o_class[CLS_ZERO] = (i_value[`FP_SIGN_POS-1:0] == '0);

    assign o_class[CLS_NORMAL]  = !exp_zero && !special;
    assign o_class[CLS_SUBNORM] = exp_zero && !frac_zero;
    assign o_class[CLS_INF]     = special && frac_zero;

    // quiet bit is the fraction MSB
    assign o_class[CLS_QNAN] = is_nan && frac[`FP_FRAC_WIDTH-1];
    assign o_class[CLS_SNAN] = is_nan && !frac[`FP_FRAC_WIDTH-1];

    assign o_class[CLS_FINITE] = o_class[CLS_NORMAL] || o_class[CLS_SUBNORM];

    // magnitude at the largest finite value
    assign o_class[CLS_CLAMPED] = (i_value[`FP_SIGN_POS-1:0] == `FP_MAG_MAX);

    // smallest normal, exponent one with empty fraction
    assign o_class[CLS_EBMIN] = (exp_field == fp_exp_t'(1)) && frac_zero;

endmodule

/* verilog/fp_exception_rules.sv */
`timescale 1ns/1ps

module fp_exception_rules
    import fp_check_pkg::*;
(
    input  fp_class_t              i_a_class,
    input  fp_class_t              i_b_class,
    input  fp_class_t              i_c_class,
    input  fp_class_t              i_res_class,
    input  fp_flags_t              i_flags,
    output logic [R_EXACT_SUB:0]   o_viol
);

    logic a_nan;
    logic b_nan;
    logic c_nan;
    logic any_nan;
    logic any_snan;
    logic res_nan;

    logic flg_nv;
    logic flg_dz;
    logic flg_of;
    logic flg_uf;
    logic flg_nx;

    // operand NaN terms
    assign a_nan = i_a_class[CLS_QNAN] || i_a_class[CLS_SNAN];
    assign b_nan = i_b_class[CLS_QNAN] || i_b_class[CLS_SNAN];
    assign c_nan = i_c_class[CLS_QNAN] || i_c_class[CLS_SNAN];

    assign any_nan  = a_nan || b_nan || c_nan;
    assign any_snan = i_a_class[CLS_SNAN] || i_b_class[CLS_SNAN] || i_c_class[CLS_SNAN];

    assign res_nan = i_res_class[CLS_QNAN] || i_res_class[CLS_SNAN];

    assign flg_nv = i_flags[FLG_NV];
    assign flg_dz = i_flags[FLG_DZ];
    assign flg_of = i_flags[FLG_OF];
    assign flg_uf = i_flags[FLG_UF];
    assign flg_nx = i_flags[FLG_NX];

    // a NaN operand must come out as a NaN
    assign o_viol[R_NAN_PROP] = any_nan && !res_nan;

    // NaN operands raise nothing but NV
    assign o_viol[R_NAN_QUIET] = any_nan && (flg_dz || flg_of || flg_uf || flg_nx);

    // signalling NaN always raises invalid
    assign o_viol[R_SNAN_NV] = any_snan && !flg_nv;

    // divide by zero yields an infinity
    assign o_viol[R_DZ_INF] = flg_dz && !i_res_class[CLS_INF];

    // invalid yields the default quiet NaN
    assign o_viol[R_NV_QNAN] = flg_nv && !i_res_class[CLS_QNAN];

    // overflow and underflow are always inexact
    assign o_viol[R_OF_NX] = flg_of && !flg_nx;
    assign o_viol[R_UF_NX] = flg_uf && !flg_nx;

    // an underflowed result is tiny: subnormal, zero or the smallest normal
    assign o_viol[R_UF_CLASS] = flg_uf && !(i_res_class[CLS_SUBNORM] ||
                                            i_res_class[CLS_ZERO] ||
                                            i_res_class[CLS_EBMIN]);

    // infinity without overflow came from an exact operand
    assign o_viol[R_EXACT_INF] = i_res_class[CLS_INF] && !flg_of && flg_nx;

    // subnormal without underflow is exact
    assign o_viol[R_EXACT_SUB] = i_res_class[CLS_SUBNORM] && !flg_uf && flg_nx;

endmodule

/* verilog/fp_result_monitor.sv */
`timescale 1ns/1ps

module fp_result_monitor
    import fp_check_pkg::*;
(
    input  logic      clk,
    input  logic      i_rst,
    input  logic      i_valid,
    input  fp32_t     i_a,
    input  fp32_t     i_b,
    input  fp32_t     i_c,
    input  rm_t       i_rm,
    input  fp32_t     i_result,
    input  fp_flags_t i_flags,
    output logic      o_valid,
    output rule_vec_t o_rule_viol,
    output vcount_t   o_viol_count
);

    // stage 1 transaction registers
    logic      s1_valid;
    fp32_t     s1_a;
    fp32_t     s1_b;
    fp32_t     s1_c;
    rm_t       s1_rm;
    fp32_t     s1_result;
    fp_flags_t s1_flags;

    fp_class_t a_class;
    fp_class_t b_class;
    fp_class_t c_class;
    fp_class_t res_class;

    logic [R_EXACT_SUB:0]          exc_viol;
    logic [R_RM_ONEHOT:R_OF_VALUE] rnd_viol;
    rule_vec_t                     rule_vec;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= i_valid;
        end
    end

    // payload only loads on an accepted transaction
    always_ff @(posedge clk) begin
        if (i_valid) begin
            s1_a      <= i_a;
            s1_b      <= i_b;
            s1_c      <= i_c;
            s1_rm     <= i_rm;
            s1_result <= i_result;
            s1_flags  <= i_flags;
        end
    end

    fp_classify u_cls_a (
        .i_value (s1_a),
        .o_class (a_class)
    );

    fp_classify u_cls_b (
        .i_value (s1_b),
        .o_class (b_class)
    );

    fp_classify u_cls_c (
        .i_value (s1_c),
        .o_class (c_class)
    );

    fp_classify u_cls_res (
        .i_value (s1_result),
        .o_class (res_class)
    );

    fp_exception_rules u_exception_rules (
        .i_a_class   (a_class),
        .i_b_class   (b_class),
        .i_c_class   (c_class),
        .i_res_class (res_class),
        .i_flags     (s1_flags),
        .o_viol      (exc_viol)
    );

    fp_rounding_rules u_rounding_rules (
        .i_rm        (s1_rm),
        .i_result    (s1_result),
        .i_res_class (res_class),
        .i_flags     (s1_flags),
        .o_viol      (rnd_viol)
    );

    // rounding rules occupy the top bits of the vector
    assign rule_vec = {rnd_viol, exc_viol};

    // stage 2, the rule vector holds until the next output transaction
    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_valid     <= 1'b0;
            o_rule_viol <= '0;
        end else begin
            o_valid <= s1_valid;
            if (s1_valid) begin
                o_rule_viol <= rule_vec;
            end
        end
    end

    // count failing results, new value shows up together with o_valid
    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_viol_count <= '0;
        end else if (s1_valid && (rule_vec != '0)) begin
            // hold at the top instead of wrapping
            if (o_viol_count != '1) begin
                o_viol_count <= o_viol_count + vcount_t'(1);
            end
        end
    end

endmodule

/* verilog/fp_rounding_rules.sv */
`timescale 1ns/1ps
`include "fp_check_macros.svh"

module fp_rounding_rules
    import fp_check_pkg::*;
(
    input  rm_t                              i_rm,
    input  fp32_t                            i_result,
    input  fp_class_t                        i_res_class,
    input  fp_flags_t                        i_flags,
    output logic [R_RM_ONEHOT:R_OF_VALUE]    o_viol
);

    rm_t  rm_dec;
    rm_t  rm_low;
    logic rm_onehot;
    logic of_value_ok;
    logic toward_sign;
    logic dir_ok;
    logic at_edge;

    // priority decode from bit 0 upward, nothing set falls through to RTZ
    always_comb begin
        rm_dec = '0;
        if (i_rm[RM_RNE]) begin
            rm_dec[RM_RNE] = 1'b1;
        end else if (i_rm[RM_RNA]) begin
            rm_dec[RM_RNA] = 1'b1;
        end else if (i_rm[RM_RTP]) begin
            rm_dec[RM_RTP] = 1'b1;
        end else if (i_rm[RM_RTN]) begin
            rm_dec[RM_RTN] = 1'b1;
        end else begin
            rm_dec[RM_RTZ] = 1'b1;
        end
    end

    // clearing the lowest set bit leaves zero only for a single bit
    assign rm_low    = i_rm & (i_rm - rm_t'(1));
    assign rm_onehot = (i_rm != '0) && (rm_low == '0);

    // overflow value allowed by each mode
    always_comb begin
        if (rm_dec[RM_RNE] || rm_dec[RM_RNA]) begin
            of_value_ok = i_res_class[CLS_INF];
        end else if (rm_dec[RM_RTP]) begin
            of_value_ok = (i_result == `FP_POS_INF) || (i_result == `FP_NEG_MAX);
        end else if (rm_dec[RM_RTN]) begin
            of_value_ok = (i_result == `FP_POS_MAX) || (i_result == `FP_NEG_INF);
        end else begin
            of_value_ok = (i_result == `FP_POS_MAX) || (i_result == `FP_NEG_MAX);
        end
    end

    // directed modes only round away from zero toward their own infinity
    assign toward_sign = i_res_class[CLS_SIGN] ? rm_dec[RM_RTN] : rm_dec[RM_RTP];
    assign dir_ok      = rm_dec[RM_RNE] || rm_dec[RM_RNA] || toward_sign;

    // result sits on an edge reachable only by rounding outward
    assign at_edge = (i_flags[FLG_UF] && i_res_class[CLS_EBMIN]) ||
                     (i_flags[FLG_OF] && i_res_class[CLS_INF]);

    assign o_viol[R_OF_VALUE]  = i_flags[FLG_OF] && !of_value_ok;
    assign o_viol[R_DIRECTION] = at_edge && !dir_ok;
    assign o_viol[R_RM_ONEHOT] = !rm_onehot;

endmodule
